// ==== list.f ====
hw/rip_pkg.sv
hw/rip_host_port.sv
hw/rip_fetch.sv
hw/rip_decode.sv
hw/rip_execute.sv
hw/rip_memory.sv
hw/rip_top.sv
tests/rip_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -f list.f --top-module rip_tb -o rip_sim
	./obj_dir/rip_sim > $(LOG) 2>&1 || echo "** FAIL **" >> $(LOG)
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/rip_tb.sv ====
`timescale 1ns/1ps

module rip_tb;

    localparam int          n_tests     = 5;
    localparam logic [11:0] ctrl_addr   = 12'h800;
    localparam logic [11:0] status_addr = 12'h804;

    logic        clk;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] prog [$];

    rip_top rip_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(n_tests * 2000 * 10);
        $display("watchdog expired after %0d cycles", n_tests * 2000);
        $display("** FAIL **");
        $finish;
    end

    // instruction encoders
    function automatic logic [31:0] rr_op(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_op(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_op(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] lw_op(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_op(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // f3 is 0 for beq, 1 for bne
    function automatic logic [31:0] branch_op(input int f3, input int rs1, input int rs2,
                                              input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jal_op(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [11:0] dmem_addr(input int idx);
        return {2'b01, idx[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] sext12(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // access phase outputs are settled by the falling edge
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] ignored;
        apb_access(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    // ebreak plus nops so nothing stale follows it down the pipe
    task automatic load_program();
        logic err;
        int   i;
        prog.push_back(32'h0010_0073);
        repeat (4) prog.push_back(addi_op(0, 0, 0));
        for (i = 0; i < prog.size(); i++) begin
            apb_write({2'b00, i[7:0], 2'b00}, prog[i], err);
            assert (!err) else begin
                $display("imem write of word %0d was refused", i);
                errors++;
            end
        end
    endtask

    task automatic start_core();
        logic err;
        apb_write(ctrl_addr, 32'h1, err);
        check_value("pslverr on run", 32'(err), 32'h0);
    endtask

    task automatic wait_halt(output logic [31:0] status);
        logic err;
        int   polls;
        polls  = 0;
        status = '0;
        while (status[1] !== 1'b1 && polls < 1000) begin
            apb_read(status_addr, status, err);
            polls++;
        end
        assert (status[1] === 1'b1) else begin
            $display("core did not halt after %0d status reads", polls);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic host_access_test();
        int          start_errors;
        logic [31:0] data;
        logic [31:0] word;
        logic        err;
        start_errors = errors;
        apb_read(status_addr, data, err);
        check_value("status after reset", data, 32'h0);
        word = $random(seed);
        apb_write(dmem_addr(3), word, err);
        check_value("pslverr on dmem write", 32'(err), 32'h0);
        apb_read(dmem_addr(3), data, err);
        check_value("dmem[3]", data, word);
        check_value("pslverr on dmem read", 32'(err), 32'h0);
        apb_read(12'hc00, data, err);
        check_value("pslverr on unmapped read", 32'(err), 32'h1);
        apb_read(12'h010, data, err);
        check_value("pslverr on imem read", 32'(err), 32'h1);
        report_test("host access", start_errors);
    endtask

    task automatic arith_forward_test();
        int          start_errors;
        int          u;
        int          ia;
        int          ib;
        int          k;
        logic [31:0] v [8];
        logic [31:0] vb;
        logic [31:0] data;
        logic        err;
        start_errors = errors;
        u  = $random(seed);
        ia = $random(seed);
        ib = $random(seed);
        v[0] = {u[19:0], 12'h000};
        v[1] = v[0] + sext12(ia);
        vb   = sext12(ib);
        v[2] = v[1] + vb;
        v[3] = v[2] - v[0];
        v[4] = v[3] & v[1];
        v[5] = v[4] | vb;
        v[6] = v[5] ^ v[2];
        v[7] = ($signed(v[6]) < $signed(v[3])) ? 32'h1 : 32'h0;
        prog.delete();
        prog.push_back(lui_op(1, u));
        prog.push_back(addi_op(2, 1, ia));
        prog.push_back(addi_op(10, 0, ib));
        prog.push_back(rr_op(0, 0, 3, 2, 10));
        prog.push_back(rr_op(32, 0, 4, 3, 1));
        prog.push_back(rr_op(0, 7, 5, 4, 2));
        prog.push_back(rr_op(0, 6, 6, 5, 10));
        prog.push_back(rr_op(0, 4, 7, 6, 3));
        prog.push_back(rr_op(0, 2, 8, 7, 4));
        for (k = 1; k <= 8; k++) begin
            prog.push_back(sw_op(k, 0, 4 * (k - 1)));
        end
        load_program();
        start_core();
        wait_halt(data);
        for (k = 0; k < 8; k++) begin
            apb_read(dmem_addr(k), data, err);
            check_value($sformatf("dmem[%0d]", k), data, v[k]);
        end
        report_test("arithmetic forwarding", start_errors);
    endtask

    task automatic load_use_test();
        int          start_errors;
        int          addend;
        logic [31:0] word;
        logic [31:0] data;
        logic        err;
        start_errors = errors;
        word   = $random(seed);
        addend = $random(seed);
        apb_write(dmem_addr(8), word, err);
        prog.delete();
        prog.push_back(addi_op(11, 0, addend));
        prog.push_back(lw_op(12, 0, 32));
        prog.push_back(rr_op(0, 0, 13, 12, 11));
        prog.push_back(sw_op(13, 0, 36));
        load_program();
        start_core();
        wait_halt(data);
        apb_read(dmem_addr(9), data, err);
        check_value("dmem[9]", data, word + sext12(addend));
        report_test("load use", start_errors);
    endtask

    task automatic control_flow_test();
        int          start_errors;
        int          n;
        int          jal_pc;
        logic [31:0] data;
        logic        err;
        start_errors = errors;
        n = ($random(seed) & 7) + 1;
        prog.delete();
        prog.push_back(addi_op(5, 0, n));
        prog.push_back(addi_op(6, 0, 0));
        // count loop
        prog.push_back(addi_op(6, 6, 1));
        prog.push_back(addi_op(5, 5, -1));
        prog.push_back(branch_op(1, 5, 0, -8));
        prog.push_back(sw_op(6, 0, 64));
        prog.push_back(addi_op(7, 0, 85));
        prog.push_back(branch_op(0, 0, 0, 8));
        prog.push_back(addi_op(7, 0, 102));
        prog.push_back(branch_op(0, 5, 6, 8));
        prog.push_back(addi_op(8, 0, 17));
        prog.push_back(sw_op(7, 0, 68));
        prog.push_back(sw_op(8, 0, 72));
        jal_pc = prog.size() * 4;
        prog.push_back(jal_op(9, 8));
        prog.push_back(addi_op(9, 0, 0));
        prog.push_back(sw_op(9, 0, 76));
        load_program();
        start_core();
        wait_halt(data);
        apb_read(dmem_addr(16), data, err);
        check_value("loop count", data, 32'(n));
        apb_read(dmem_addr(17), data, err);
        check_value("marker", data, 32'h55);
        apb_read(dmem_addr(18), data, err);
        check_value("fall through", data, 32'h11);
        apb_read(dmem_addr(19), data, err);
        check_value("jal link", data, 32'(jal_pc + 4));
        report_test("control flow", start_errors);
    endtask

    task automatic busy_write_test();
        int          start_errors;
        logic [31:0] old_word;
        logic [31:0] data;
        logic        err;
        start_errors = errors;
        old_word = $random(seed);
        apb_write(dmem_addr(20), old_word, err);
        prog.delete();
        prog.push_back(addi_op(5, 0, 150));
        prog.push_back(addi_op(5, 5, -1));
        prog.push_back(branch_op(1, 5, 0, -4));
        load_program();
        start_core();
        apb_read(status_addr, data, err);
        check_value("status busy bit", {31'b0, data[0]}, 32'h1);
        apb_write(dmem_addr(20), ~old_word, err);
        check_value("pslverr on busy write", 32'(err), 32'h1);
        wait_halt(data);
        check_value("status after halt", data, 32'h2);
        apb_read(dmem_addr(20), data, err);
        check_value("dmem[20]", data, old_word);
        report_test("busy write", start_errors);
    endtask

    initial begin
        seed         = 32'hbd5e_8153;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        host_access_test();
        arith_forward_test();
        load_use_test();
        control_flow_test();
        busy_write_test();

        $display("tests passed %0d failed %0d, %0d errors", tests_passed, tests_failed,
                 errors);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== hw/rip_top.sv ====
`timescale 1ns/1ps

module rip_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    // host side
    logic        imem_we;
    logic        dmem_we;
    logic [7:0]  host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        run_start;
    logic        busy;
    logic        halt;

    // fetch and control
    logic        if_valid;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic        load_stall;
    logic        redirect;
    logic [31:0] redirect_pc;

    // decode to execute
    logic        de_valid;
    logic [31:0] de_pc;
    logic [6:0]  de_opcode;
    logic [2:0]  de_alu_op;
    logic [31:0] de_rs1_val, de_rs2_val, de_imm;
    logic [4:0]  de_rd;
    logic        de_reg_wen, de_is_load, de_is_store, de_is_branch_ne, de_is_ebreak;

    // execute to memory
    logic        ex_valid;
    logic [31:0] ex_result, ex_store_data;
    logic [4:0]  ex_rd;
    logic        ex_reg_wen, ex_is_load, ex_is_store, ex_is_ebreak;

    // memory stage and writeback
    logic [4:0]  mem_rd, wb_rd;
    logic        mem_wen, wb_valid, wb_wen;
    logic [31:0] mem_data, wb_data;

    rip_host_port #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) rip_host_port_i (.*);

    rip_fetch #(.IMEM_WORDS(IMEM_WORDS)) rip_fetch_i (.*);

    rip_decode rip_decode_i (.*);

    rip_execute rip_execute_i (.*);

    rip_memory #(.DMEM_WORDS(DMEM_WORDS)) rip_memory_i (.*);

endmodule

// ==== hw/rip_memory.sv ====
`timescale 1ns/1ps

module rip_memory
    import rip_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       ex_store_data,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  ex_reg_wen,
    input  logic                  ex_is_load,
    input  logic                  ex_is_store,
    input  logic                  ex_is_ebreak,
    input  logic                  dmem_we,
    input  logic [7:0]            host_addr,
    input  logic [xlen-1:0]       host_wdata,
    output logic [xlen-1:0]       host_rdata,
    output logic [reg_addr_w-1:0] mem_rd,
    output logic                  mem_wen,
    output logic [xlen-1:0]       mem_data,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic                  wb_wen,
    output logic [xlen-1:0]       wb_data,
    output logic                  halt
);
    logic [xlen-1:0] dmem [DMEM_WORDS];
    logic [xlen-1:0] load_data;
    logic            wb_is_ebreak;

    // host port and core store port
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[host_addr] <= host_wdata;
        end
        if (ex_valid && ex_is_store) begin
            dmem[ex_result[9:2]] <= ex_store_data;
        end
    end

    assign host_rdata = dmem[host_addr];
    assign load_data  = dmem[ex_result[9:2]];

    // memory-stage result, also the forwarding source
    assign mem_rd   = ex_rd;
    assign mem_wen  = ex_reg_wen;
    assign mem_data = ex_is_load ? load_data : ex_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_wen       <= 1'b0;
            wb_is_ebreak <= 1'b0;
        end else begin
            wb_valid     <= ex_valid;
            wb_wen       <= ex_reg_wen;
            wb_is_ebreak <= ex_is_ebreak;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_data;
    end

    assign halt = wb_valid & wb_is_ebreak;

endmodule

// ==== hw/rip_execute.sv ====
`timescale 1ns/1ps

module rip_execute
    import rip_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  de_valid,
    input  logic [xlen-1:0]       de_pc,
    input  logic [6:0]            de_opcode,
    input  logic [2:0]            de_alu_op,
    input  logic [xlen-1:0]       de_rs1_val,
    input  logic [xlen-1:0]       de_rs2_val,
    input  logic [xlen-1:0]       de_imm,
    input  logic [reg_addr_w-1:0] de_rd,
    input  logic                  de_reg_wen,
    input  logic                  de_is_load,
    input  logic                  de_is_store,
    input  logic                  de_is_branch_ne,
    input  logic                  de_is_ebreak,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc,
    output logic                  ex_valid,
    output logic [xlen-1:0]       ex_result,
    output logic [xlen-1:0]       ex_store_data,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  ex_reg_wen,
    output logic                  ex_is_load,
    output logic                  ex_is_store,
    output logic                  ex_is_ebreak
);
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;
    logic            taken;

    // register operand only for R-type
    assign op_b = (de_opcode == op) ? de_rs2_val : de_imm;

    always_comb begin
        case (de_alu_op)
            add:     alu_out = de_rs1_val + op_b;
            sub:     alu_out = de_rs1_val - op_b;
            and_op:  alu_out = de_rs1_val & op_b;
            or_op:   alu_out = de_rs1_val | op_b;
            xor_op:  alu_out = de_rs1_val ^ op_b;
            slt:     alu_out = {31'b0, $signed(de_rs1_val) < $signed(op_b)};
            pass_b:  alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    // jal writes the link value
    assign result = (de_opcode == jal) ? de_pc + xlen'(4) : alu_out;

    assign taken       = (de_opcode == branch) &&
                         ((de_rs1_val == de_rs2_val) ^ de_is_branch_ne);
    assign redirect    = de_valid && (taken || de_opcode == jal);
    assign redirect_pc = de_pc + de_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_wen   <= 1'b0;
            ex_is_load   <= 1'b0;
            ex_is_store  <= 1'b0;
            ex_is_ebreak <= 1'b0;
        end else begin
            ex_valid     <= de_valid;
            ex_reg_wen   <= de_valid & de_reg_wen;
            ex_is_load   <= de_valid & de_is_load;
            ex_is_store  <= de_valid & de_is_store;
            ex_is_ebreak <= de_valid & de_is_ebreak;
        end
    end

    always_ff @(posedge clk) begin
        ex_result     <= result;
        ex_store_data <= de_rs2_val;
        ex_rd         <= de_rd;
    end

endmodule

// ==== hw/rip_decode.sv ====
`timescale 1ns/1ps

module rip_decode
    import rip_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  if_valid,
    input  logic [xlen-1:0]       if_pc,
    input  logic [xlen-1:0]       if_inst,
    input  logic                  redirect,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  ex_reg_wen,
    input  logic                  ex_is_load,
    input  logic [xlen-1:0]       ex_result,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_wen,
    input  logic [xlen-1:0]       wb_data,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic                  mem_wen,
    input  logic [xlen-1:0]       mem_data,
    output logic                  load_stall,
    output logic                  de_valid,
    output logic [xlen-1:0]       de_pc,
    output opcode_e               de_opcode,
    output alu_op_e               de_alu_op,
    output logic [xlen-1:0]       de_rs1_val,
    output logic [xlen-1:0]       de_rs2_val,
    output logic [xlen-1:0]       de_imm,
    output logic [reg_addr_w-1:0] de_rd,
    output logic                  de_reg_wen,
    output logic                  de_is_load,
    output logic                  de_is_store,
    output logic                  de_is_branch_ne,
    output logic                  de_is_ebreak
);
    opcode_e               opcode;
    alu_op_e               alu_op;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rs1_num;
    logic [reg_addr_w-1:0] rs2_num;
    logic [xlen-1:0]       imm;
    logic                  reg_wen;
    logic [xlen-1:0]       regs [32];
    logic                  rf_we;
    logic [xlen-1:0]       rs1_rf;
    logic [xlen-1:0]       rs2_rf;
    logic [reg_addr_w-1:0] de_rs1_num;
    logic [reg_addr_w-1:0] de_rs2_num;
    logic [xlen-1:0]       de_rs1_rf;
    logic [xlen-1:0]       de_rs2_rf;

    assign opcode  = opcode_e'(if_inst[6:0]);
    assign funct3  = if_inst[14:12];
    assign rs1_num = if_inst[19:15];
    assign rs2_num = if_inst[24:20];

    always_comb begin
        alu_op  = add;
        imm     = {{20{if_inst[31]}}, if_inst[31:20]};
        reg_wen = 1'b0;
        case (opcode)
            op, op_imm: begin
                reg_wen = 1'b1;
                case (funct3)
                    3'b000:  alu_op = (opcode == op && if_inst[30]) ? sub : add;
                    3'b010:  alu_op = slt;
                    3'b100:  alu_op = xor_op;
                    3'b110:  alu_op = or_op;
                    3'b111:  alu_op = and_op;
                    default: alu_op = add;
                endcase
            end
            lui: begin
                reg_wen = 1'b1;
                alu_op  = pass_b;
                imm     = {if_inst[31:12], 12'b0};
            end
            load: reg_wen = 1'b1;
            store: imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            branch: begin
                imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                       if_inst[11:8], 1'b0};
            end
            jal: begin
                reg_wen = 1'b1;
                imm     = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                           if_inst[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // register file, written from writeback with write-through to the read ports
    assign rf_we  = wb_valid && wb_wen && (wb_rd != '0);
    assign rs1_rf = (rs1_num == '0) ? '0 :
                    (rf_we && wb_rd == rs1_num) ? wb_data : regs[rs1_num];
    assign rs2_rf = (rs2_num == '0) ? '0 :
                    (rf_we && wb_rd == rs2_num) ? wb_data : regs[rs2_num];

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // a dependent of a load in execute waits one cycle
    assign load_stall = if_valid && de_valid && de_is_load && (de_rd != '0) &&
                        (de_rd == rs1_num || de_rd == rs2_num);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= if_valid && !load_stall && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        de_pc           <= if_pc;
        de_opcode       <= opcode;
        de_alu_op       <= alu_op;
        de_imm          <= imm;
        de_rd           <= if_inst[11:7];
        de_reg_wen      <= reg_wen;
        de_is_load      <= (opcode == load);
        de_is_store     <= (opcode == store);
        de_is_branch_ne <= (opcode == branch) && funct3[0];
        de_is_ebreak    <= (opcode == system) && (if_inst[31:20] == 12'h001);
        de_rs1_num      <= rs1_num;
        de_rs2_num      <= rs2_num;
        de_rs1_rf       <= rs1_rf;
        de_rs2_rf       <= rs2_rf;
    end

    // nearest producer wins
    function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] num,
                                            input logic [xlen-1:0]       rf_val);
        if (num == '0) begin
            return rf_val;
        end
        if (ex_reg_wen && !ex_is_load && ex_rd == num) begin
            return ex_result;
        end
        if (mem_wen && mem_rd == num) begin
            return mem_data;
        end
        if (wb_valid && wb_wen && wb_rd == num) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        de_rs1_val = fwd(de_rs1_num, de_rs1_rf);
        de_rs2_val = fwd(de_rs2_num, de_rs2_rf);
    end

endmodule

// ==== hw/rip_fetch.sv ====
`timescale 1ns/1ps

module rip_fetch
    import rip_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            imem_we,
    input  logic [7:0]      host_addr,
    input  logic [xlen-1:0] host_wdata,
    input  logic            run_start,
    input  logic            halt,
    input  logic            load_stall,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    output logic            busy,
    output logic            if_valid,
    output logic [xlen-1:0] if_pc,
    output logic [xlen-1:0] if_inst
);
    logic [xlen-1:0] imem [IMEM_WORDS];
    logic [xlen-1:0] pc;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[host_addr] <= host_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            pc       <= start_addr;
            if_valid <= 1'b0;
        end else begin
            if (run_start) begin
                busy <= 1'b1;
            end else if (halt) begin
                busy <= 1'b0;
            end

            if (run_start) begin
                pc       <= start_addr;
                if_valid <= 1'b0;
            end else if (!busy || halt) begin
                if_valid <= 1'b0;
            end else if (redirect) begin
                // younger instruction in flight is dropped
                pc       <= redirect_pc;
                if_valid <= 1'b0;
            end else if (!load_stall) begin
                pc       <= pc + xlen'(4);
                if_valid <= 1'b1;
            end
        end
    end

    // hold the fetched word during a load-use stall
    always_ff @(posedge clk) begin
        if (!load_stall) begin
            if_pc   <= pc;
            if_inst <= imem[pc[9:2]];
        end
    end

endmodule

// ==== hw/rip_host_port.sv ====
`timescale 1ns/1ps

module rip_host_port
    import rip_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [11:0]     paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [xlen-1:0] pwdata,
    output logic [xlen-1:0] prdata,
    output logic            pready,
    output logic            pslverr,
    input  logic            busy,
    input  logic            halt,
    input  logic [xlen-1:0] host_rdata,
    output logic            imem_we,
    output logic            dmem_we,
    output logic [7:0]      host_addr,
    output logic [xlen-1:0] host_wdata,
    output logic            run_start
);
    logic       access;
    logic [7:0] word_idx;
    logic       in_imem;
    logic       in_dmem;
    logic       is_ctrl;
    logic       is_status;
    logic       mem_hit;
    logic       halted;

    assign access   = psel & penable;
    assign word_idx = paddr[9:2];

    // both windows are 1 KiB aligned
    assign in_imem   = (paddr[11:10] == host_imem_base[11:10]) && (int'(word_idx) < IMEM_WORDS);
    assign in_dmem   = (paddr[11:10] == host_dmem_base[11:10]) && (int'(word_idx) < DMEM_WORDS);
    assign is_ctrl   = (paddr == host_ctrl_addr);
    assign is_status = (paddr == host_status_addr);
    assign mem_hit   = in_imem | in_dmem;

    // memory writes are dropped while the core runs
    assign imem_we    = access & pwrite & in_imem & ~busy;
    assign dmem_we    = access & pwrite & in_dmem & ~busy;
    assign host_addr  = word_idx;
    assign host_wdata = pwdata;

    assign pready  = 1'b1;
    assign pslverr = access & (~(mem_hit | is_ctrl | is_status) |
                               (~pwrite & in_imem) |
                               (pwrite & mem_hit & busy));

    always_comb begin
        prdata = '0;
        if (in_dmem) begin
            prdata = host_rdata;
        end else if (is_status) begin
            prdata = {30'b0, halted, busy};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_start <= 1'b0;
            halted    <= 1'b0;
        end else begin
            run_start <= access & pwrite & is_ctrl & pwdata[0] & ~busy;
            if (run_start) begin
                halted <= 1'b0;
            end else if (halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/rip_pkg.sv ====
package rip_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        slt,
        pass_b
    } alu_op_e;

    // APB map, one word per register
    localparam logic [11:0] host_imem_base   = 12'h000;
    localparam logic [11:0] host_dmem_base   = 12'h400;
    localparam logic [11:0] host_ctrl_addr   = 12'h800;
    localparam logic [11:0] host_status_addr = 12'h804;

    localparam logic [xlen-1:0] start_addr = 32'h0000_0000;

endpackage
